// File: common/sysctl_pkg.sv
package sysctl_pkg;

	// Bus widths of the shared Wishbone port
	localparam int ADR_WIDTH = 32;
	localparam int DAT_WIDTH = 32;
	localparam int SEL_WIDTH = DAT_WIDTH / 8;

	// Word address after the region nibble is masked and the byte offset dropped
	localparam int WORD_ADR_WIDTH = 26;

	// Block RAM geometry
	localparam int BRAM_WORDS = 2048;
	localparam int BRAM_ADR_WIDTH = $clog2(BRAM_WORDS);

	// Addresses below this select the RAM
	localparam int BRAM_BYTES = BRAM_WORDS * SEL_WIDTH;

	// Region nibble position in the bus address
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 28;

	// Address map, one nibble per peripheral region
	localparam logic [3:0] RTC_REGION = 4'h9;
	localparam logic [3:0] DEBUG_REGION = 4'he;

	// Free-running counter width, kept short so the wrap comes often
	localparam int RTC_WIDTH = 10;

	// Debug LED outputs
	localparam int LED_WIDTH = 8;

endpackage

// File: rtl/bus_decode.sv
module bus_decode (
	input  logic [sysctl_pkg::ADR_WIDTH-1:0]      wb_adr_i,
	input  logic                                  wb_cyc_i,
	output logic                                  cs_bram_o,
	output logic                                  cs_rtc_o,
	output logic                                  cs_debug_o,
	output logic                                  cyc_bram_o,
	output logic                                  cyc_rtc_o,
	output logic                                  cyc_debug_o,
	output logic [sysctl_pkg::WORD_ADR_WIDTH-1:0] word_adr_o
);

	import sysctl_pkg::*;

	logic [REGION_MSB-REGION_LSB:0] region;

	assign region = wb_adr_i[REGION_MSB:REGION_LSB];

	// RAM limit and region nibble compares
	assign cs_bram_o = (wb_adr_i < ADR_WIDTH'(BRAM_BYTES));
	assign cs_rtc_o = (region == RTC_REGION);
	assign cs_debug_o = (region == DEBUG_REGION);

	// Per-slave cycle strobes
	assign cyc_bram_o = wb_cyc_i && cs_bram_o;
	assign cyc_rtc_o = wb_cyc_i && cs_rtc_o;
	assign cyc_debug_o = wb_cyc_i && cs_debug_o;

	// Region bits masked off, byte offset dropped
	assign word_adr_o = wb_adr_i[REGION_LSB-1:2];

endmodule

// File: rtl/bram_slave.sv
module bram_slave (
	input  logic                                  sys_clk,
	input  logic                                  sys_rstn,
	input  logic [sysctl_pkg::WORD_ADR_WIDTH-1:0] word_adr_i,
	input  logic [sysctl_pkg::DAT_WIDTH-1:0]      dat_i,
	input  logic [sysctl_pkg::SEL_WIDTH-1:0]      sel_i,
	input  logic                                  we_i,
	input  logic                                  stb_i,
	input  logic                                  cyc_i,
	output logic [sysctl_pkg::DAT_WIDTH-1:0]      dat_o,
	output logic                                  ack_o
);

	import sysctl_pkg::*;

	logic [DAT_WIDTH-1:0] mem [BRAM_WORDS];
	logic [BRAM_ADR_WIDTH-1:0] idx;
	logic req;

	// Upper word address bits alias onto the RAM
	assign idx = word_adr_i[BRAM_ADR_WIDTH-1:0];

	// Taken once per transfer, the ack blocks a second sample
	assign req = cyc_i && stb_i && !ack_o;

	always_ff @(posedge sys_clk) begin
		if (!sys_rstn) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
		end
	end

	// Byte-lane writes and registered read
	always_ff @(posedge sys_clk) begin
		if (req) begin
			dat_o <= mem[idx];
			if (we_i) begin
				for (int i = 0; i < SEL_WIDTH; i++) begin
					if (sel_i[i])
						mem[idx][8*i +: 8] <= dat_i[8*i +: 8];
				end
			end
		end
	end

	// An ack always answers a cycle seen on the edge before
	ack_after_cyc: assert property (
		@(posedge sys_clk) disable iff (!sys_rstn)
		ack_o |-> $past(cyc_i)
	) else $error("bram_slave: ack without a preceding cycle");

endmodule

// File: rtl/rtc_timer.sv
module rtc_timer (
	input  logic                             sys_clk,
	input  logic                             sys_rstn,
	input  logic                             stb_i,
	input  logic                             cyc_i,
	output logic [sysctl_pkg::DAT_WIDTH-1:0] dat_o,
	output logic                             ack_o,
	output logic                             irq_timer_o
);

	import sysctl_pkg::*;

	logic [RTC_WIDTH-1:0] rtc_ctr;
	logic req;

	assign req = cyc_i && stb_i && !ack_o;

	// Free-running counter, wraps every 2^RTC_WIDTH cycles
	always_ff @(posedge sys_clk) begin
		if (!sys_rstn) begin
			rtc_ctr <= '0;
		end else begin
			rtc_ctr <= rtc_ctr + 1'b1;
		end
	end

	// One-cycle pulse on the edge after the counter sits at zero
	always_ff @(posedge sys_clk) begin
		if (!sys_rstn) begin
			irq_timer_o <= 1'b0;
		end else begin
			irq_timer_o <= (rtc_ctr == '0);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rstn) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
		end
	end

	// Read only, a write is acked and dropped
	always_ff @(posedge sys_clk) begin
		if (req)
			dat_o <= DAT_WIDTH'(rtc_ctr);
	end

	irq_single_cycle: assert property (
		@(posedge sys_clk) disable iff (!sys_rstn)
		irq_timer_o |=> !irq_timer_o
	) else $error("rtc_timer: timer interrupt held for two cycles");

endmodule

// File: rtl/debug_leds.sv
module debug_leds (
	input  logic                             sys_clk,
	input  logic                             sys_rstn,
	input  logic [sysctl_pkg::DAT_WIDTH-1:0] dat_i,
	input  logic [sysctl_pkg::SEL_WIDTH-1:0] sel_i,
	input  logic                             we_i,
	input  logic                             stb_i,
	input  logic                             cyc_i,
	output logic [sysctl_pkg::DAT_WIDTH-1:0] dat_o,
	output logic                             ack_o,
	output logic [sysctl_pkg::LED_WIDTH-1:0] dbg_leds_o
);

	import sysctl_pkg::*;

	logic [LED_WIDTH-1:0] leds_q;
	logic req;

	assign req = cyc_i && stb_i && !ack_o;

	// LED state and handshake
	always_ff @(posedge sys_clk) begin
		if (!sys_rstn) begin
			leds_q <= '0;
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
			// Only byte lane 0 carries the LEDs
			if (req && we_i && sel_i[0])
				leds_q <= dat_i[LED_WIDTH-1:0];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (req)
			dat_o <= DAT_WIDTH'(leds_q);
	end

	assign dbg_leds_o = leds_q;

endmodule

// File: rtl/response_mux.sv
module response_mux (
	input  logic                             cs_bram_i,
	input  logic                             cs_rtc_i,
	input  logic                             cs_debug_i,
	input  logic [sysctl_pkg::DAT_WIDTH-1:0] bram_dat_i,
	input  logic                             bram_ack_i,
	input  logic [sysctl_pkg::DAT_WIDTH-1:0] rtc_dat_i,
	input  logic                             rtc_ack_i,
	input  logic [sysctl_pkg::DAT_WIDTH-1:0] debug_dat_i,
	input  logic                             debug_ack_i,
	output logic [sysctl_pkg::DAT_WIDTH-1:0] wb_dat_o,
	output logic                             wb_ack_o
);

	import sysctl_pkg::*;

	// Fixed priority in map order; an unmapped address gets no ack,
	// so the master waits on it forever
	always_comb begin
		if (cs_bram_i) begin
			wb_dat_o = bram_dat_i;
			wb_ack_o = bram_ack_i;
		end else if (cs_rtc_i) begin
			wb_dat_o = rtc_dat_i;
			wb_ack_o = rtc_ack_i;
		end else if (cs_debug_i) begin
			wb_dat_o = debug_dat_i;
			wb_ack_o = debug_ack_i;
		end else begin
			wb_dat_o = {DAT_WIDTH{1'b0}};
			wb_ack_o = 1'b0;
		end
	end

endmodule

// File: rtl/sysctl_top.sv
module sysctl_top (
	input  logic                             sys_clk,
	input  logic                             sys_rstn,
	input  logic [sysctl_pkg::ADR_WIDTH-1:0] wb_adr_i,
	input  logic [sysctl_pkg::DAT_WIDTH-1:0] wb_dat_i,
	input  logic [sysctl_pkg::SEL_WIDTH-1:0] wb_sel_i,
	input  logic                             wb_we_i,
	input  logic                             wb_stb_i,
	input  logic                             wb_cyc_i,
	output logic [sysctl_pkg::DAT_WIDTH-1:0] wb_dat_o,
	output logic                             wb_ack_o,
	output logic                             irq_timer_o,
	output logic [sysctl_pkg::LED_WIDTH-1:0] dbg_leds_o
);

	import sysctl_pkg::*;

	logic cs_bram, cs_rtc, cs_debug;
	logic cyc_bram, cyc_rtc, cyc_debug;
	logic [WORD_ADR_WIDTH-1:0] word_adr;
	logic [DAT_WIDTH-1:0] bram_dat, rtc_dat, debug_dat;
	logic bram_ack, rtc_ack, debug_ack;

	// Decode
	bus_decode u_decode (
		.wb_adr_i(wb_adr_i), .wb_cyc_i(wb_cyc_i),
		.cs_bram_o(cs_bram), .cs_rtc_o(cs_rtc), .cs_debug_o(cs_debug),
		.cyc_bram_o(cyc_bram), .cyc_rtc_o(cyc_rtc), .cyc_debug_o(cyc_debug),
		.word_adr_o(word_adr)
	);

	// Slaves
	bram_slave u_bram (
		.sys_clk(sys_clk), .sys_rstn(sys_rstn), .word_adr_i(word_adr),
		.dat_i(wb_dat_i), .sel_i(wb_sel_i), .we_i(wb_we_i), .stb_i(wb_stb_i),
		.cyc_i(cyc_bram), .dat_o(bram_dat), .ack_o(bram_ack)
	);

	rtc_timer u_rtc (
		.sys_clk(sys_clk), .sys_rstn(sys_rstn), .stb_i(wb_stb_i), .cyc_i(cyc_rtc),
		.dat_o(rtc_dat), .ack_o(rtc_ack), .irq_timer_o(irq_timer_o)
	);

	debug_leds u_debug (
		.sys_clk(sys_clk), .sys_rstn(sys_rstn), .dat_i(wb_dat_i), .sel_i(wb_sel_i),
		.we_i(wb_we_i), .stb_i(wb_stb_i), .cyc_i(cyc_debug),
		.dat_o(debug_dat), .ack_o(debug_ack), .dbg_leds_o(dbg_leds_o)
	);

	// Return path
	response_mux u_mux (
		.cs_bram_i(cs_bram), .cs_rtc_i(cs_rtc), .cs_debug_i(cs_debug),
		.bram_dat_i(bram_dat), .bram_ack_i(bram_ack),
		.rtc_dat_i(rtc_dat), .rtc_ack_i(rtc_ack),
		.debug_dat_i(debug_dat), .debug_ack_i(debug_ack),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o)
	);

endmodule

// File: testbench/tb_sysctl.sv
module tb_sysctl;

	import sysctl_pkg::*;

	localparam int TIMEOUT_CYCLES = 6000;
	localparam int RAM_TEST_WORDS = 64;
	localparam int RTC_PERIOD = 1 << RTC_WIDTH;

	logic sys_clk;
	logic sys_rstn;
	logic [ADR_WIDTH-1:0] wb_adr_i;
	logic [DAT_WIDTH-1:0] wb_dat_i;
	logic [SEL_WIDTH-1:0] wb_sel_i;
	logic wb_we_i;
	logic wb_stb_i;
	logic wb_cyc_i;
	logic [DAT_WIDTH-1:0] wb_dat_o;
	logic wb_ack_o;
	logic irq_timer_o;
	logic [LED_WIDTH-1:0] dbg_leds_o;

	logic [15:0] lfsr_state;
	logic [DAT_WIDTH-1:0] ram_model [RAM_TEST_WORDS];
	logic [LED_WIDTH-1:0] led_model;
	logic mon_en;
	int edge_cnt;
	int cycle_cnt;
	int irq_pulses;

	sysctl_top uut (
		.sys_clk(sys_clk), .sys_rstn(sys_rstn),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_we_i(wb_we_i), .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.irq_timer_o(irq_timer_o), .dbg_leds_o(dbg_leds_o)
	);

	initial begin
		sys_clk = 1'b0;
	end

	always #4 sys_clk = ~sys_clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// Byte lanes with their select bit set take the new data
	function automatic logic [DAT_WIDTH-1:0] merge_lanes(input logic [DAT_WIDTH-1:0] old_word,
		input logic [DAT_WIDTH-1:0] new_word, input logic [SEL_WIDTH-1:0] sel);
		logic [DAT_WIDTH-1:0] res;
		res = old_word;
		for (int i = 0; i < SEL_WIDTH; i++) begin
			if (sel[i])
				res[8*i +: 8] = new_word[8*i +: 8];
		end
		return res;
	endfunction

	// Rising edges since reset release, plus the run limit
	always @(posedge sys_clk) begin
		if (!sys_rstn)
			edge_cnt <= 0;
		else
			edge_cnt <= edge_cnt + 1;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// Pulse expected after edge 1, then once per counter period
	always @(negedge sys_clk) begin
		if (mon_en) begin
			check_value("irq_timer_o", 32'(irq_timer_o),
				32'((edge_cnt % RTC_PERIOD) == 1));
			if (irq_timer_o)
				irq_pulses++;
		end
	end

	// One transfer, started on a falling edge; ack must come one cycle later
	task automatic bus_transfer(input logic [ADR_WIDTH-1:0] adr, input logic we,
		input logic [DAT_WIDTH-1:0] dat, input logic [SEL_WIDTH-1:0] sel,
		output logic [DAT_WIDTH-1:0] rdat, output int edge_at_req);
		int wait_cycles;
		wb_adr_i = adr;
		wb_dat_i = dat;
		wb_sel_i = sel;
		wb_we_i = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		edge_at_req = edge_cnt;
		wait_cycles = 0;
		do begin
			@(negedge sys_clk);
			wait_cycles++;
		end while (!wb_ack_o);
		check_value("wb_ack_o latency", 32'(wait_cycles), 32'd1);
		rdat = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		@(negedge sys_clk);
		check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
	endtask

	task automatic ram_tests();
		logic [31:0] op;
		logic [31:0] w;
		logic [31:0] d;
		logic [31:0] s;
		logic [DAT_WIDTH-1:0] rd;
		int e;
		int idx;
		// Full-word fill so every later read has a known value
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			rand_bits(32, d);
			bus_transfer(ADR_WIDTH'(i) << 2, 1'b1, d, '1, rd, e);
			ram_model[i] = d;
		end
		for (int n = 0; n < 300; n++) begin
			rand_bits(1, op);
			rand_bits(6, w);
			rand_bits(32, d);
			rand_bits(4, s);
			idx = int'(w[5:0]);
			if (op[0]) begin
				bus_transfer(ADR_WIDTH'(idx) << 2, 1'b1, d, s[3:0], rd, e);
				ram_model[idx] = merge_lanes(ram_model[idx], d, s[3:0]);
			end else begin
				bus_transfer(ADR_WIDTH'(idx) << 2, 1'b0, d, s[3:0], rd, e);
				check_value("wb_dat_o", rd, ram_model[idx]);
			end
		end
	endtask

	task automatic led_tests();
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] s;
		logic [DAT_WIDTH-1:0] rd;
		int e;
		for (int n = 0; n < 20; n++) begin
			rand_bits(28, a);
			rand_bits(32, d);
			rand_bits(4, s);
			bus_transfer({DEBUG_REGION, a[27:0]}, 1'b1, d, s[3:0], rd, e);
			if (s[0])
				led_model = d[LED_WIDTH-1:0];
			check_value("dbg_leds_o", 32'(dbg_leds_o), 32'(led_model));
			bus_transfer({DEBUG_REGION, a[27:0]}, 1'b0, '0, '0, rd, e);
			check_value("wb_dat_o", rd, 32'(led_model));
		end
	endtask

	task automatic rtc_tests();
		logic [31:0] a;
		logic [31:0] op;
		logic [31:0] gap;
		logic [DAT_WIDTH-1:0] rd;
		int e;
		for (int n = 0; n < 10; n++) begin
			rand_bits(28, a);
			rand_bits(1, op);
			rand_bits(3, gap);
			repeat (int'(gap[2:0])) @(negedge sys_clk);
			bus_transfer({RTC_REGION, a[27:0]}, op[0], '1, '1, rd, e);
			check_value("wb_dat_o", rd, 32'(e % RTC_PERIOD));
		end
	endtask

	// The region nibble picks the slave, the RAM word stays untouched
	task automatic alias_tests();
		logic [31:0] w;
		logic [31:0] d;
		logic [DAT_WIDTH-1:0] rd;
		int e;
		int idx;
		for (int n = 0; n < 8; n++) begin
			rand_bits(6, w);
			rand_bits(32, d);
			idx = int'(w[5:0]);
			bus_transfer({DEBUG_REGION, 28'(idx) << 2}, 1'b1, d, '1, rd, e);
			led_model = d[LED_WIDTH-1:0];
			check_value("dbg_leds_o", 32'(dbg_leds_o), 32'(led_model));
			bus_transfer(ADR_WIDTH'(idx) << 2, 1'b0, '0, '0, rd, e);
			check_value("wb_dat_o", rd, ram_model[idx]);
			bus_transfer({RTC_REGION, 28'(idx) << 2}, 1'b0, '0, '0, rd, e);
			check_value("wb_dat_o", rd, 32'(e % RTC_PERIOD));
		end
	endtask

	initial begin
		lfsr_state = 16'd50;
		mon_en = 1'b0;
		led_model = '0;
		sys_rstn = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		wb_we_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rstn = 1'b1;
		mon_en = 1'b1;
		check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
		check_value("dbg_leds_o", 32'(dbg_leds_o), 32'd0);
		ram_tests();
		led_tests();
		rtc_tests();
		alias_tests();
		// Idle until four pulses, three full counter periods
		while (irq_pulses < 4) begin
			@(negedge sys_clk);
			check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: sim.f
common/sysctl_pkg.sv
rtl/bus_decode.sv
rtl/bram_slave.sv
rtl/rtc_timer.sv
rtl/debug_leds.sv
rtl/response_mux.sv
rtl/sysctl_top.sv
testbench/tb_sysctl.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, decide from the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tb_sysctl -f sim.f -o tb_sysctl \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sysctl > sim.log 2>&1
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && { echo "Simulation failed"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0
